// File: sica_defs.svh
`ifndef SICA_DEFS_SVH
`define SICA_DEFS_SVH

// Vector geometry
`define SICA_DIM            7
`define SICA_VEC_COUNT      8

// Datapath widths
`define SICA_SAMPLE_WIDTH   16
`define SICA_ELEM_WIDTH     17
`define SICA_NORM_WIDTH     20
`define SICA_CORDIC_WIDTH   22

// Number of CORDIC micro-rotations
`define SICA_CORDIC_STAGES  16

// Difference norm at or below this counts as converged
`define SICA_THRESHOLD      32

// 1/K in Q1.15
`define SICA_GAIN_INV       19898

`endif

// File: sica_pkg.sv
`include "sica_defs.svh"

package sica_pkg;

    typedef logic signed [`SICA_SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [`SICA_ELEM_WIDTH-1:0]   elem_t;
    typedef logic        [`SICA_NORM_WIDTH-1:0]   norm_t;

    // Element 0 sits in the low bits
    typedef elem_t [`SICA_DIM-1:0] vec_t;

    // One vectoring pass, x is the running magnitude
    typedef struct packed {
        norm_t x;
        elem_t y;
    } cordic_req_t;

    typedef struct packed {
        norm_t norm;
        norm_t diff_norm;
        logic  converged;
    } sica_result_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_NORM,
        S_CHECK,
        S_OUTPUT,
        S_COMPLETE
    } ctrl_state_t;

endpackage

// File: sample_loader.sv
`timescale 1ns/1ps
`include "sica_defs.svh"

module sample_loader
    import sica_pkg::*;
(
    input  logic    clk,
    input  logic    nreset,
    input  sample_t z_in,
    input  logic    z_valid,
    output logic    z_ready,
    output vec_t    vec,
    output logic    vec_valid,
    input  logic    vec_take
);

    localparam int CW = $clog2(`SICA_DIM + 1);
    localparam logic [CW-1:0] FULL = CW'(`SICA_DIM);

    logic [CW-1:0] count;
    logic          accept;

    assign vec_valid = (count == FULL);
    assign z_ready   = !vec_valid;
    assign accept    = z_valid && z_ready;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            count <= '0;
        end else if (vec_take) begin
            count <= '0;
        end else if (accept) begin
            count <= count + 1'b1;
        end
    end

    // Sign extension into the element slot
    always_ff @(posedge clk) begin
        if (accept) begin
            vec[count] <= elem_t'(z_in);
        end
    end

endmodule

// File: cordic_vec.sv
`timescale 1ns/1ps
`include "sica_defs.svh"

module cordic_vec
    import sica_pkg::*;
(
    input  logic        clk,
    input  logic        nreset,
    input  logic        req,
    output logic        ack,
    input  cordic_req_t operand,
    output norm_t       magnitude
);

    localparam int W     = `SICA_CORDIC_WIDTH;
    localparam int N     = `SICA_NORM_WIDTH;
    localparam int GUARD = 2;
    localparam int PW    = W + 16;
    localparam int SW    = $clog2(`SICA_CORDIC_STAGES + 1);
    localparam logic [SW-1:0] LAST = SW'(`SICA_CORDIC_STAGES);

    logic signed [W-1:0] xr;
    logic signed [W-1:0] yr;
    logic signed [W-1:0] y_ext;
    logic signed [W-1:0] y_abs;
    logic [SW-1:0]       step;
    logic                busy;
    logic [PW-1:0]       prod;
    logic [PW-1:0]       rounded;

    assign y_ext = W'(operand.y);
    assign y_abs = (y_ext < 0) ? -y_ext : y_ext;

    // Gain compensation, x stays non-negative in vectoring mode
    assign prod    = PW'(unsigned'(xr)) * PW'(`SICA_GAIN_INV);
    assign rounded = (prod + (PW'(1) << (14 + GUARD))) >> (15 + GUARD);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            busy <= 1'b0;
            ack  <= 1'b0;
            step <= '0;
        end else if (busy) begin
            if (step == LAST) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end
            step <= step + 1'b1;
        end else if (ack) begin
            if (!req) begin
                ack <= 1'b0;
            end
        end else if (req) begin
            busy <= 1'b1;
            step <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && !ack && req) begin
            // Two guard bits below the LSB
            xr <= W'(operand.x) << GUARD;
            yr <= y_abs <<< GUARD;
        end else if (busy && step != LAST) begin
            if (yr < 0) begin
                xr <= xr - (yr >>> step);
                yr <= yr + (xr >>> step);
            end else begin
                xr <= xr + (yr >>> step);
                yr <= yr - (xr >>> step);
            end
        end else if (busy) begin
            magnitude <= (|rounded[PW-1:N]) ? '1 : rounded[N-1:0];
        end
    end

endmodule

// File: cordic_arbiter.sv
`timescale 1ns/1ps

module cordic_arbiter
    import sica_pkg::*;
(
    input  logic        clk,
    input  logic        nreset,
    input  logic        c0_req,
    output logic        c0_ack,
    input  cordic_req_t c0_op,
    input  logic        c1_req,
    output logic        c1_ack,
    input  cordic_req_t c1_op,
    output logic        core_req,
    input  logic        core_ack,
    output cordic_req_t core_op,
    input  norm_t       magnitude,
    output norm_t       c0_mag,
    output norm_t       c1_mag
);

    logic busy;
    logic owner;
    logic dropped;
    logic own_req;

    assign own_req = owner ? c1_req : c0_req;
    assign core_op = owner ? c1_op : c0_op;

    // Ack reaches only the owner and never after it has dropped req
    assign c0_ack = busy && !owner && c0_req && core_ack && !dropped;
    assign c1_ack = busy && owner && c1_req && core_ack && !dropped;

    assign c0_mag = magnitude;
    assign c1_mag = magnitude;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            busy     <= 1'b0;
            owner    <= 1'b0;
            dropped  <= 1'b0;
            core_req <= 1'b0;
        end else if (!busy) begin
            dropped <= 1'b0;
            if (c0_req) begin
                busy     <= 1'b1;
                owner    <= 1'b0;
                core_req <= 1'b1;
            end else if (c1_req) begin
                busy     <= 1'b1;
                owner    <= 1'b1;
                core_req <= 1'b1;
            end
        end else begin
            if (!own_req) begin
                dropped  <= 1'b1;
                core_req <= 1'b0;
            end
            // Core must finish its return-to-zero before a new grant
            if (dropped && !core_ack && !core_req) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: vec_norm.sv
`timescale 1ns/1ps
`include "sica_defs.svh"

module vec_norm
    import sica_pkg::*;
(
    input  logic        clk,
    input  logic        nreset,
    input  logic        norm_req,
    output logic        norm_ack,
    input  vec_t        vec,
    output norm_t       norm,
    output logic        cordic_req,
    input  logic        cordic_ack,
    output cordic_req_t cordic_op,
    input  norm_t       cordic_mag
);

    localparam int IW = $clog2(`SICA_DIM);
    localparam logic [IW-1:0] LAST = IW'(`SICA_DIM - 1);

    typedef enum logic [1:0] {
        N_IDLE,
        N_REQ,
        N_DROP,
        N_DONE
    } norm_state_t;

    norm_state_t   state;
    logic [IW-1:0] idx;
    norm_t         mag;

    assign cordic_op.x = mag;
    assign cordic_op.y = vec[idx];
    assign norm        = mag;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state      <= N_IDLE;
            idx        <= '0;
            cordic_req <= 1'b0;
            norm_ack   <= 1'b0;
        end else begin
            case (state)
                N_IDLE: if (norm_req) begin
                    idx        <= '0;
                    cordic_req <= 1'b1;
                    state      <= N_REQ;
                end
                N_REQ: if (cordic_ack) begin
                    cordic_req <= 1'b0;
                    state      <= N_DROP;
                end
                N_DROP: if (!cordic_ack) begin
                    if (idx == LAST) begin
                        norm_ack <= 1'b1;
                        state    <= N_DONE;
                    end else begin
                        idx        <= idx + 1'b1;
                        cordic_req <= 1'b1;
                        state      <= N_REQ;
                    end
                end
                N_DONE: if (!norm_req) begin
                    norm_ack <= 1'b0;
                    state    <= N_IDLE;
                end
                default: state <= N_IDLE;
            endcase
        end
    end

    // Running magnitude, replaced by each pass result
    always_ff @(posedge clk) begin
        if (state == N_IDLE && norm_req) begin
            mag <= '0;
        end else if (state == N_REQ && cordic_ack) begin
            mag <= cordic_mag;
        end
    end

endmodule

// File: sica_ctrl.sv
`timescale 1ns/1ps
`include "sica_defs.svh"

module sica_ctrl
    import sica_pkg::*;
(
    input  logic         clk,
    input  logic         nreset,
    input  logic         sica_start,
    input  vec_t         vec,
    input  logic         vec_valid,
    output logic         vec_take,
    output logic         norm_req,
    input  logic [1:0]   norm_ack,
    output vec_t         diff_vec,
    output vec_t         cur_vec,
    input  norm_t        norm_in,
    input  norm_t        diff_in,
    output sica_result_t res,
    output logic         res_req,
    input  logic         res_ack,
    output logic         sica_complete
);

    localparam int VW = $clog2(`SICA_VEC_COUNT);
    localparam logic [VW-1:0] LAST_VEC = VW'(`SICA_VEC_COUNT - 1);
    localparam norm_t THRESH = norm_t'(`SICA_THRESHOLD);

    ctrl_state_t   state;
    logic [VW-1:0] vec_cnt;
    vec_t          prev_vec;
    logic          start_run;
    logic          take;
    logic          norms_done;

    assign start_run  = sica_start && (state == S_IDLE || state == S_COMPLETE);
    // Both norm units must be back at rest before a new request
    assign take       = (state == S_LOAD) && vec_valid && (norm_ack == 2'b00);
    assign norms_done = (state == S_NORM) && (&norm_ack);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state         <= S_IDLE;
            vec_cnt       <= '0;
            vec_take      <= 1'b0;
            norm_req      <= 1'b0;
            res_req       <= 1'b0;
            sica_complete <= 1'b0;
        end else begin
            vec_take <= take;
            case (state)
                S_IDLE: if (start_run) begin
                    vec_cnt <= '0;
                    state   <= S_LOAD;
                end
                S_LOAD: if (take) begin
                    norm_req <= 1'b1;
                    state    <= S_NORM;
                end
                S_NORM: if (norms_done) begin
                    norm_req <= 1'b0;
                    state    <= S_CHECK;
                end
                S_CHECK: state <= S_OUTPUT;
                S_OUTPUT: begin
                    if (!res_req) begin
                        if (!res_ack) begin
                            res_req <= 1'b1;
                        end
                    end else if (res_ack) begin
                        res_req <= 1'b0;
                        if (vec_cnt == LAST_VEC) begin
                            state <= S_COMPLETE;
                        end else begin
                            vec_cnt <= vec_cnt + 1'b1;
                            state   <= S_LOAD;
                        end
                    end
                end
                S_COMPLETE: begin
                    if (start_run) begin
                        sica_complete <= 1'b0;
                        vec_cnt       <= '0;
                        state         <= S_LOAD;
                    end else if (!res_ack) begin
                        sica_complete <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // First vector of a run is compared against zero
        if (start_run) begin
            prev_vec <= '0;
        end
        if (take) begin
            cur_vec  <= vec;
            prev_vec <= vec;
            for (int i = 0; i < `SICA_DIM; i++) begin
                diff_vec[i] <= vec[i] - prev_vec[i];
            end
        end
        if (norms_done) begin
            res.norm      <= norm_in;
            res.diff_norm <= diff_in;
        end
        if (state == S_CHECK) begin
            res.converged <= (res.diff_norm <= THRESH);
        end
    end

endmodule

// File: sica_top.sv
`timescale 1ns/1ps

module sica_top
    import sica_pkg::*;
(
    input  logic         clk,
    input  logic         nreset,
    input  logic         sica_start,
    input  sample_t      z_in,
    input  logic         z_valid,
    output logic         z_ready,
    output sica_result_t res,
    output logic         res_req,
    input  logic         res_ack,
    output logic         sica_complete
);

    vec_t        vec;
    vec_t        cur_vec;
    vec_t        diff_vec;
    logic        vec_valid;
    logic        vec_take;
    logic        norm_req;
    logic        norm_ack_n;
    logic        diff_ack;
    norm_t       norm_val;
    norm_t       diff_val;
    logic        c0_req;
    logic        c0_ack;
    logic        c1_req;
    logic        c1_ack;
    logic        core_req;
    logic        core_ack;
    cordic_req_t c0_op;
    cordic_req_t c1_op;
    cordic_req_t core_op;
    norm_t       c0_mag;
    norm_t       c1_mag;
    norm_t       core_mag;

    sample_loader u_loader (
        .clk       (clk),
        .nreset    (nreset),
        .z_in      (z_in),
        .z_valid   (z_valid),
        .z_ready   (z_ready),
        .vec       (vec),
        .vec_valid (vec_valid),
        .vec_take  (vec_take)
    );

    sica_ctrl u_ctrl (
        .clk           (clk),
        .nreset        (nreset),
        .sica_start    (sica_start),
        .vec           (vec),
        .vec_valid     (vec_valid),
        .vec_take      (vec_take),
        .norm_req      (norm_req),
        .norm_ack      ({diff_ack, norm_ack_n}),
        .diff_vec      (diff_vec),
        .cur_vec       (cur_vec),
        .norm_in       (norm_val),
        .diff_in       (diff_val),
        .res           (res),
        .res_req       (res_req),
        .res_ack       (res_ack),
        .sica_complete (sica_complete)
    );

    // Client 0 of the arbiter, higher priority
    vec_norm u_norm (
        .clk        (clk),
        .nreset     (nreset),
        .norm_req   (norm_req),
        .norm_ack   (norm_ack_n),
        .vec        (cur_vec),
        .norm       (norm_val),
        .cordic_req (c0_req),
        .cordic_ack (c0_ack),
        .cordic_op  (c0_op),
        .cordic_mag (c0_mag)
    );

    vec_norm u_diff (
        .clk        (clk),
        .nreset     (nreset),
        .norm_req   (norm_req),
        .norm_ack   (diff_ack),
        .vec        (diff_vec),
        .norm       (diff_val),
        .cordic_req (c1_req),
        .cordic_ack (c1_ack),
        .cordic_op  (c1_op),
        .cordic_mag (c1_mag)
    );

    cordic_arbiter u_arb (
        .clk       (clk),
        .nreset    (nreset),
        .c0_req    (c0_req),
        .c0_ack    (c0_ack),
        .c0_op     (c0_op),
        .c1_req    (c1_req),
        .c1_ack    (c1_ack),
        .c1_op     (c1_op),
        .core_req  (core_req),
        .core_ack  (core_ack),
        .core_op   (core_op),
        .magnitude (core_mag),
        .c0_mag    (c0_mag),
        .c1_mag    (c1_mag)
    );

    cordic_vec u_cordic (
        .clk       (clk),
        .nreset    (nreset),
        .req       (core_req),
        .ack       (core_ack),
        .operand   (core_op),
        .magnitude (core_mag)
    );

endmodule

// File: sica_chk.sv
`timescale 1ns/1ps

module sica_chk
    import sica_pkg::*;
(
    input logic         clk,
    input logic         nreset,
    input sica_result_t res,
    input logic         res_req,
    input logic         res_ack,
    input logic         c0_req,
    input logic         c0_ack,
    input logic         c1_req,
    input logic         c1_ack,
    input logic         z_ready,
    input logic         vec_valid,
    input logic         vec_take
);

    // Result held from request until acknowledge
    a_res_stable: assert property (@(posedge clk) disable iff (!nreset)
        (res_req && !res_ack) |=> $stable(res))
        else $error("res changed while res_req waited for res_ack");

    a_req_after_ack: assert property (@(posedge clk) disable iff (!nreset)
        $rose(res_req) |-> !$past(res_ack))
        else $error("res_req rose while res_ack was still high");

    // No ack in the same cycle as a fresh request
    a_c0_ack: assert property (@(posedge clk) disable iff (!nreset)
        c0_ack |-> (c0_req && $past(c0_req)))
        else $error("arbiter client 0 acked without a standing request");

    a_c1_ack: assert property (@(posedge clk) disable iff (!nreset)
        c1_ack |-> (c1_req && $past(c1_req)))
        else $error("arbiter client 1 acked without a standing request");

    // Full loader stays full and closed until the controller takes it
    a_loader_full: assert property (@(posedge clk) disable iff (!nreset)
        (vec_valid && !vec_take) |=> (vec_valid && !z_ready))
        else $error("loader opened or emptied before its full vector was taken");

endmodule

// Arbiter client handshakes are the c0/c1 nets around u_arb
bind sica_top sica_chk u_chk (
    .clk       (clk),
    .nreset    (nreset),
    .res       (res),
    .res_req   (res_req),
    .res_ack   (res_ack),
    .c0_req    (c0_req),
    .c0_ack    (c0_ack),
    .c1_req    (c1_req),
    .c1_ack    (c1_ack),
    .z_ready   (z_ready),
    .vec_valid (vec_valid),
    .vec_take  (vec_take)
);

// File: tb_sica.sv
`timescale 1ns/1ps
`include "sica_defs.svh"

module tb_sica
    import sica_pkg::*;
();

    localparam int  DIM     = `SICA_DIM;
    localparam int  VEC     = `SICA_VEC_COUNT;
    localparam int  RUNS    = 2;
    localparam int  TIMEOUT = 4000;
    localparam real THRESH  = `SICA_THRESHOLD;

    logic         clk = 1'b0;
    logic         nreset;
    logic         sica_start;
    sample_t      z_in;
    logic         z_valid;
    logic         z_ready;
    sica_result_t res;
    logic         res_req;
    logic         res_ack;
    logic         sica_complete;

    // One run of stimulus, ack delay per row and the expected results
    sample_t stim [VEC][DIM];
    int      ack_delay [VEC] = '{0, 3, 0, 25, 1, 70, 2, 9};
    real     exp_norm [VEC];
    real     exp_diff [VEC];
    bit      exp_conv [VEC];

    logic [31:0] lfsr_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;

    sica_top dut (
        .clk           (clk),
        .nreset        (nreset),
        .sica_start    (sica_start),
        .z_in          (z_in),
        .z_valid       (z_valid),
        .z_ready       (z_ready),
        .res           (res),
        .res_req       (res_req),
        .res_ack       (res_ack),
        .sica_complete (sica_complete)
    );

    always #50 clk = ~clk;

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic bit within_tol(input norm_t got, input real expected);
        real err;
        err = real'(got) - expected;
        if (err < 0.0) begin
            err = -err;
        end
        return err <= 8.0 + 0.005 * expected;
    endfunction

    task automatic fill_table();
        logic [31:0] r;
        int          v;
        for (int row = 0; row < VEC; row++) begin
            for (int c = 0; c < DIM; c++) begin
                stim[row][c] = '0;
            end
        end
        // Row 0 all zero, row 1 a single element, row 2 repeats row 1
        stim[1][3] = -16'sd1234;
        for (int c = 0; c < DIM; c++) begin
            stim[2][c] = stim[1][c];
            stim[3][c] = 16'sh7fff;
            stim[4][c] = 16'sh8000;
        end
        for (int row = 5; row < 7; row++) begin
            for (int c = 0; c < DIM; c++) begin
                take_bits(16, r);
                stim[row][c] = sample_t'(r[15:0]);
            end
        end
        // Last row sits a few LSB away from row 6, so it should converge
        for (int c = 0; c < DIM; c++) begin
            take_bits(3, r);
            v = int'(stim[6][c]) + int'(r[2:0]) - 4;
            stim[7][c] = sample_t'(v);
        end
    endtask

    task automatic compute_expected();
        real sum_n;
        real sum_d;
        real d;
        real tol;
        for (int r = 0; r < VEC; r++) begin
            sum_n = 0.0;
            sum_d = 0.0;
            for (int c = 0; c < DIM; c++) begin
                d = real'(int'(stim[r][c]));
                sum_n += d * d;
                if (r > 0) begin
                    d = d - real'(int'(stim[r-1][c]));
                end
                sum_d += d * d;
            end
            exp_norm[r] = $sqrt(sum_n);
            exp_diff[r] = $sqrt(sum_d);
            exp_conv[r] = (exp_diff[r] <= THRESH);
            tol = 8.0 + 0.005 * exp_diff[r];
            if (exp_diff[r] - THRESH <= tol && THRESH - exp_diff[r] <= tol) begin
                $display("Stimulus row %0d has a difference norm too close to the threshold", r);
                error_count++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        error_count += errs;
        if (errs == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d mismatches", name, errs);
        end
    endtask

    task automatic check_reset_state();
        int errs;
        errs = 0;
        if (res_req !== 1'b0) begin
            $display("Mismatch at %0t: res_req got %b expected 0", $time, res_req);
            errs++;
        end
        if (sica_complete !== 1'b0) begin
            $display("Mismatch at %0t: sica_complete got %b expected 0", $time, sica_complete);
            errs++;
        end
        if (z_ready !== 1'b1) begin
            $display("Mismatch at %0t: z_ready got %b expected 1", $time, z_ready);
            errs++;
        end
        report_test("reset state", errs);
    endtask

    // z_valid stays high for the whole run, junk is offered while the loader is full
    task automatic feed_samples();
        int waited;
        z_valid = 1'b1;
        for (int row = 0; row < VEC; row++) begin
            for (int c = 0; c < DIM; c++) begin
                waited = 0;
                while (!z_ready && waited < TIMEOUT && !timed_out) begin
                    z_in = 16'sh5a5a;
                    @(negedge clk);
                    waited++;
                end
                if (timed_out) begin
                    z_valid = 1'b0;
                    return;
                end
                if (!z_ready) begin
                    $display("Timeout at %0t: z_ready stayed low, row %0d sample %0d not taken",
                             $time, row, c);
                    error_count++;
                    timed_out = 1'b1;
                    z_valid = 1'b0;
                    return;
                end
                z_in = stim[row][c];
                @(negedge clk);
            end
        end
        z_valid = 1'b0;
    endtask

    task automatic collect_results(input int run);
        int    waited;
        int    errs;
        string name;
        for (int row = 0; row < VEC; row++) begin
            errs = 0;
            waited = 0;
            name = $sformatf("run %0d row %0d", run, row);
            while (!res_req && waited < TIMEOUT && !timed_out) begin
                @(negedge clk);
                waited++;
            end
            if (!res_req) begin
                if (!timed_out) begin
                    $display("Timeout at %0t: no result request for %s", $time, name);
                    report_test(name, 1);
                end
                timed_out = 1'b1;
                return;
            end
            if (sica_complete !== 1'b0) begin
                $display("Mismatch at %0t: sica_complete got %b expected 0", $time, sica_complete);
                errs++;
            end
            if (!within_tol(res.norm, exp_norm[row])) begin
                $display("Mismatch at %0t: res.norm got %0d expected %0.2f",
                         $time, res.norm, exp_norm[row]);
                errs++;
            end
            if (!within_tol(res.diff_norm, exp_diff[row])) begin
                $display("Mismatch at %0t: res.diff_norm got %0d expected %0.2f",
                         $time, res.diff_norm, exp_diff[row]);
                errs++;
            end
            if (res.converged !== exp_conv[row]) begin
                $display("Mismatch at %0t: res.converged got %b expected %b",
                         $time, res.converged, exp_conv[row]);
                errs++;
            end
            repeat (ack_delay[row]) @(negedge clk);
            res_ack = 1'b1;
            waited = 0;
            while (res_req && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            res_ack = 1'b0;
            if (res_req) begin
                $display("Timeout at %0t: res_req stayed high after res_ack for %s", $time, name);
                errs++;
                timed_out = 1'b1;
            end
            report_test(name, errs);
            if (timed_out) begin
                return;
            end
        end
    endtask

    task automatic wait_complete(input int run);
        int    waited;
        int    errs;
        string name;
        errs = 0;
        waited = 0;
        name = $sformatf("run %0d complete", run);
        while (!sica_complete && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!sica_complete) begin
            $display("Timeout at %0t: sica_complete never rose after the last result", $time);
            timed_out = 1'b1;
            report_test(name, 1);
            return;
        end
        // Completion holds and no extra result shows up
        repeat (20) begin
            @(negedge clk);
            if (sica_complete !== 1'b1) begin
                $display("Mismatch at %0t: sica_complete got %b expected 1", $time, sica_complete);
                errs++;
            end
            if (res_req !== 1'b0) begin
                $display("Mismatch at %0t: res_req got %b expected 0", $time, res_req);
                errs++;
            end
        end
        report_test(name, errs);
    endtask

    task automatic run_once(input int run);
        int errs;
        errs = 0;
        fill_table();
        compute_expected();
        sica_start = 1'b1;
        @(negedge clk);
        sica_start = 1'b0;
        if (sica_complete !== 1'b0) begin
            $display("Mismatch at %0t: sica_complete got %b expected 0", $time, sica_complete);
            errs++;
        end
        report_test($sformatf("run %0d start", run), errs);
        fork
            feed_samples();
            collect_results(run);
        join
        if (!timed_out) begin
            wait_complete(run);
        end
    endtask

    initial begin
        nreset       = 1'b0;
        sica_start   = 1'b0;
        z_in         = '0;
        z_valid      = 1'b0;
        res_ack      = 1'b0;
        lfsr_state   = 32'd32570;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        repeat (16) @(negedge clk);
        nreset = 1'b1;
        @(negedge clk);
        check_reset_state();
        for (int run = 0; run < RUNS && !timed_out; run++) begin
            run_once(run);
        end
        $display("Summary: %0d tests, %0d failed, %0d failed checks",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sica.f
+incdir+.
sica_pkg.sv
sample_loader.sv
cordic_vec.sv
cordic_arbiter.sv
vec_norm.sv
sica_ctrl.sv
sica_top.sv
sica_chk.sv
tb_sica.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_sica
FILELIST   := sica.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Finished with no errors
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
